// File: Makefile
SOURCES = $(shell cat filelist.f)

obj_dir/Vtb_l2_way_select: filelist.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module tb_l2_way_select \
		-f filelist.f -o Vtb_l2_way_select

run: obj_dir/Vtb_l2_way_select
	obj_dir/Vtb_l2_way_select | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: filelist.f
l2_way_pkg.sv
l2_req_fifo.sv
l2_tag_store.sv
l2_plru_tree.sv
l2_way_resolver.sv
l2_way_select_top.sv
tb_l2_checker.sv
tb_l2_way_select.sv

// File: l2_plru_tree.sv
module l2_plru_tree (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [l2_way_pkg::SET_W-1:0]    rd_set,
    output logic [l2_way_pkg::WAY_W-1:0]    victim_d,
    output logic [1:0]                      victim_i,
    input  logic                            touch_en,
    input  logic [l2_way_pkg::SET_W-1:0]    touch_set,
    input  logic [l2_way_pkg::WAY_W-1:0]    touch_way
);
    import l2_way_pkg::*;

    plru_tree_t       trees [NUM_SETS];
    plru_tree_t       rd_tree;
    logic [WAY_W-1:0] walk_d;
    logic [1:0]       walk_i;

    ////////////////////
    // Victim walks
    ////////////////////

    // Full walk starts at the root
    always_comb begin
        rd_tree   = trees[rd_set];
        walk_d[2] = rd_tree[0];
        walk_d[1] = rd_tree[plru_half_idx(walk_d[2])];
        walk_d[0] = rd_tree[plru_pair_idx(walk_d[2:1])];
    end

    // Instruction walk stays below the left half node
    always_comb begin
        walk_i[1] = rd_tree[plru_half_idx(1'b0)];
        walk_i[0] = rd_tree[plru_pair_idx({1'b0, walk_i[1]})];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_d <= '0;
            victim_i <= '0;
        end else begin
            victim_d <= walk_d;
            victim_i <= walk_i;
        end
    end

    ////////////////////
    // Access update
    ////////////////////

    // Only the three nodes on the way's path change, each pointing
    // to the other side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                trees[s] <= '0;
            end
        end else if (touch_en) begin
            trees[touch_set][0] <= ~touch_way[2];
            trees[touch_set][plru_half_idx(touch_way[2])] <= ~touch_way[1];
            trees[touch_set][plru_pair_idx(touch_way[2:1])] <= ~touch_way[0];
        end
    end

endmodule

// File: l2_req_fifo.sv
module l2_req_fifo (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                push,
    input  l2_way_pkg::l2_req_t push_data,
    input  logic                pop,
    output l2_way_pkg::l2_req_t head,
    output logic                not_empty,
    output logic                credit
);
    import l2_way_pkg::*;

    l2_req_t              mem [REQ_CREDITS];
    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_CNT_W-1:0] count;
    logic                 full;

    assign full      = (count == REQ_CNT_W'(REQ_CREDITS));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back upstream per freed entry
            credit <= pop;
        end
    end

    // Upstream must hold a credit for every push
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full));

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(pop && !not_empty));

endmodule

// File: l2_tag_store.sv
module l2_tag_store (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [l2_way_pkg::SET_W-1:0]    rd_set,
    input  logic [l2_way_pkg::TAG_W-1:0]    rd_tag,
    output l2_way_pkg::l2_lookup_t          lookup,
    input  logic                            fill_en,
    input  logic [l2_way_pkg::SET_W-1:0]    fill_set,
    input  logic [l2_way_pkg::WAY_W-1:0]    fill_way,
    input  logic [l2_way_pkg::TAG_W-1:0]    fill_tag
);
    import l2_way_pkg::*;

    logic [TAG_W-1:0]    tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_WAYS-1:0] valid_vec;

    ////////////////////
    // Parallel compare
    ////////////////////

    always_comb begin
        valid_vec = valid[rd_set];
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_vec[w] && (tags[rd_set][w] == rd_tag);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup <= '0;
        end else begin
            lookup.hit   <= hit_vec;
            lookup.valid <= valid_vec;
        end
    end

    ////////////////////
    // Fill write
    ////////////////////

    // Tag array write
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_set][fill_way] <= fill_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[fill_set][fill_way] <= 1'b1;
        end
    end

    // A tag lives in at most one way of a set, which relies on the
    // resolver only filling on a miss and stalling same-set reads
    a_hit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(lookup.hit));

endmodule

// File: l2_way_pkg.sv
package l2_way_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int NUM_WAYS     = 8;
    localparam int SET_W        = 4;
    localparam int TAG_W        = 8;
    localparam int WAY_W        = 3;
    localparam int NUM_SETS     = 1 << SET_W;
    localparam int I_WAYS       = NUM_WAYS / 2;
    localparam int REQ_CREDITS  = 4;
    localparam int REQ_PTR_W    = $clog2(REQ_CREDITS);
    localparam int REQ_CNT_W    = $clog2(REQ_CREDITS + 1);
    localparam int RESP_CREDITS = 4;
    localparam int RESP_CNT_W   = $clog2(RESP_CREDITS + 1);

    ////////////////////
    // Types
    ////////////////////

    typedef struct packed {
        logic [SET_W-1:0] set_idx;
        logic [TAG_W-1:0] tag;
        logic             instr;
    } l2_req_t;

    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] way;
        logic [SET_W-1:0] set_idx;
        logic [TAG_W-1:0] tag;
    } l2_resp_t;

    typedef struct packed {
        logic [NUM_WAYS-1:0] hit;
        logic [NUM_WAYS-1:0] valid;
    } l2_lookup_t;

    // Bit 0 root, bits 1..2 halves, bits 3..6 pairs, zero points left
    typedef logic [NUM_WAYS-2:0] plru_tree_t;

    // Half node above a way, selected by the way's top bit
    function automatic logic [2:0] plru_half_idx(input logic upper);
        return upper ? 3'd2 : 3'd1;
    endfunction

    // Pair node above a way, selected by the way's top two bits
    function automatic logic [2:0] plru_pair_idx(input logic [1:0] pair);
        return 3'd3 + {1'b0, pair};
    endfunction

endpackage

// File: l2_way_resolver.sv
module l2_way_resolver (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            not_empty,
    input  l2_way_pkg::l2_req_t             head,
    output logic                            pop,
    input  l2_way_pkg::l2_lookup_t          lookup,
    input  logic [l2_way_pkg::WAY_W-1:0]    victim_d,
    input  logic [1:0]                      victim_i,
    output logic [l2_way_pkg::SET_W-1:0]    rd_set,
    output logic [l2_way_pkg::TAG_W-1:0]    rd_tag,
    output logic                            fill_en,
    output logic [l2_way_pkg::SET_W-1:0]    fill_set,
    output logic [l2_way_pkg::WAY_W-1:0]    fill_way,
    output logic [l2_way_pkg::TAG_W-1:0]    fill_tag,
    output logic                            touch_en,
    output logic [l2_way_pkg::SET_W-1:0]    touch_set,
    output logic [l2_way_pkg::WAY_W-1:0]    touch_way,
    input  logic                            resp_credit,
    output logic                            resp_valid,
    output l2_way_pkg::l2_resp_t            resp
);
    import l2_way_pkg::*;

    logic [RESP_CNT_W-1:0] credits;
    logic                  hazard;
    logic                  s1_valid;
    l2_req_t               s1_req;
    logic                  hit;
    logic [WAY_W-1:0]      hit_way;
    logic                  d_inv_found;
    logic [WAY_W-1:0]      d_inv_way;
    logic                  i_inv_found;
    logic [WAY_W-1:0]      i_inv_way;
    logic [WAY_W-1:0]      sel_way;

    ////////////////////
    // Issue
    ////////////////////

    // Same set in stage 1 must write back before the next read
    assign hazard = s1_valid && (s1_req.set_idx == head.set_idx);
    assign pop    = not_empty && (credits != '0) && !hazard;
    assign rd_set = head.set_idx;
    assign rd_tag = head.tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits  <= RESP_CNT_W'(RESP_CREDITS);
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pop;
            case ({pop, resp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_req <= head;
        end
    end

    ////////////////////
    // Way choice
    ////////////////////

    always_comb begin
        hit_way     = '0;
        d_inv_found = 1'b0;
        d_inv_way   = '0;
        i_inv_found = 1'b0;
        i_inv_way   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (lookup.hit[w]) begin
                hit_way = WAY_W'(w);
            end
            // Ascending scan leaves the highest invalid way
            if (!lookup.valid[w]) begin
                d_inv_found = 1'b1;
                d_inv_way   = WAY_W'(w);
            end
        end
        // Descending scan leaves the lowest, lower subtree only
        for (int w = I_WAYS - 1; w >= 0; w--) begin
            if (!lookup.valid[w]) begin
                i_inv_found = 1'b1;
                i_inv_way   = WAY_W'(w);
            end
        end
    end

    assign hit = |lookup.hit;

    always_comb begin
        if (hit) begin
            sel_way = hit_way;
        end else if (s1_req.instr) begin
            sel_way = i_inv_found ? i_inv_way : {1'b0, victim_i};
        end else begin
            sel_way = d_inv_found ? d_inv_way : victim_d;
        end
    end

    // Fill and touch land at the same edge as the response
    assign fill_en   = s1_valid && !hit;
    assign fill_set  = s1_req.set_idx;
    assign fill_way  = sel_way;
    assign fill_tag  = s1_req.tag;
    assign touch_en  = s1_valid;
    assign touch_set = s1_req.set_idx;
    assign touch_way = sel_way;

    ////////////////////
    // Response
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp.hit     <= hit;
            resp.way     <= sel_way;
            resp.set_idx <= s1_req.set_idx;
            resp.tag     <= s1_req.tag;
        end
    end

    // Consumer never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= RESP_CNT_W'(RESP_CREDITS));

    // Instruction fills stay in ways 0..3, hits may be anywhere
    a_instr_low_fill: assert property (@(posedge clk) disable iff (!arst_n)
        s1_valid && s1_req.instr && !hit |=> resp_valid && !resp.way[WAY_W-1]);

endmodule

// File: l2_way_select_top.sv
module l2_way_select_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  l2_way_pkg::l2_req_t     req,
    output logic                    req_credit,
    output logic                    resp_valid,
    output l2_way_pkg::l2_resp_t    resp,
    input  logic                    resp_credit
);
    import l2_way_pkg::*;

    l2_req_t          head;
    logic             not_empty;
    logic             pop;
    logic [SET_W-1:0] rd_set;
    logic [TAG_W-1:0] rd_tag;
    l2_lookup_t       lookup;
    logic [WAY_W-1:0] victim_d;
    logic [1:0]       victim_i;
    logic             fill_en;
    logic [SET_W-1:0] fill_set;
    logic [WAY_W-1:0] fill_way;
    logic [TAG_W-1:0] fill_tag;
    logic             touch_en;
    logic [SET_W-1:0] touch_set;
    logic [WAY_W-1:0] touch_way;

    // Request queue, credits flow back upstream on pop
    l2_req_fifo l2_req_fifo_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_valid),
        .push_data (req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (req_credit)
    );

    l2_tag_store l2_tag_store_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_set   (rd_set),
        .rd_tag   (rd_tag),
        .lookup   (lookup),
        .fill_en  (fill_en),
        .fill_set (fill_set),
        .fill_way (fill_way),
        .fill_tag (fill_tag)
    );

    l2_plru_tree l2_plru_tree_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_set    (rd_set),
        .victim_d  (victim_d),
        .victim_i  (victim_i),
        .touch_en  (touch_en),
        .touch_set (touch_set),
        .touch_way (touch_way)
    );

    l2_way_resolver l2_way_resolver_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .not_empty   (not_empty),
        .head        (head),
        .pop         (pop),
        .lookup      (lookup),
        .victim_d    (victim_d),
        .victim_i    (victim_i),
        .rd_set      (rd_set),
        .rd_tag      (rd_tag),
        .fill_en     (fill_en),
        .fill_set    (fill_set),
        .fill_way    (fill_way),
        .fill_tag    (fill_tag),
        .touch_en    (touch_en),
        .touch_set   (touch_set),
        .touch_way   (touch_way),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

// File: tb_l2_checker.sv
module tb_l2_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  l2_way_pkg::l2_req_t     req,
    input  logic                    req_credit,
    input  logic                    resp_valid,
    input  l2_way_pkg::l2_resp_t    resp,
    input  logic                    resp_credit,
    input  int                      test_id,
    output int                      mismatch_count,
    output int                      protocol_count
);
    import l2_way_pkg::*;

    logic [TAG_W-1:0]    ref_tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] ref_valid [NUM_SETS];
    plru_tree_t          ref_tree  [NUM_SETS];
    l2_req_t             pend_req  [$];
    int                  pend_test [$];
    int                  up_in_use;
    int                  resp_held;

    function automatic string test_label(input int id);
        case (id)
            1:       return "reset_fill";
            2:       return "instr_place";
            3:       return "plru_replace";
            4:       return "same_set";
            5:       return "credits";
            6:       return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    // Heap order, children of node n at 2n+1 and 2n+2, leaf of way w at w+7
    function automatic int tree_victim(input plru_tree_t t, input int start);
        int node;
        node = start;
        while (node < NUM_WAYS - 1) begin
            node = 2 * node + 1 + int'(t[node]);
        end
        return node - (NUM_WAYS - 1);
    endfunction

    function automatic plru_tree_t tree_touch(input plru_tree_t t, input int way);
        plru_tree_t nt;
        int         node;
        int         parent;
        nt   = t;
        node = way + NUM_WAYS - 1;
        while (node != 0) begin
            parent = (node - 1) / 2;
            // Point to the sibling of the branch just used
            nt[parent] = (node == 2 * parent + 1);
            node = parent;
        end
        return nt;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic l2_resp_t expected_resp(input l2_req_t r);
        l2_resp_t e;
        int       way;
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[r.set_idx][w] && ref_tags[r.set_idx][w] == r.tag) begin
                way = w;
            end
        end
        e.hit = (way >= 0);
        if (way < 0 && r.instr) begin
            // Lowest free way of the lower subtree
            for (int w = 0; w < I_WAYS; w++) begin
                if (way < 0 && !ref_valid[r.set_idx][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = tree_victim(ref_tree[r.set_idx], 1);
            end
        end else if (way < 0) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (way < 0 && !ref_valid[r.set_idx][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = tree_victim(ref_tree[r.set_idx], 0);
            end
        end
        if (!e.hit) begin
            ref_tags[r.set_idx][way]  = r.tag;
            ref_valid[r.set_idx][way] = 1'b1;
        end
        ref_tree[r.set_idx] = tree_touch(ref_tree[r.set_idx], way);
        e.way     = WAY_W'(way);
        e.set_idx = r.set_idx;
        e.tag     = r.tag;
        return e;
    endfunction

    initial begin
        mismatch_count = 0;
        protocol_count = 0;
    end

    ////////////////////
    // Compare
    ////////////////////

    always @(negedge clk) begin : compare
        l2_resp_t exp_resp;
        l2_req_t  r;
        int       id;
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                ref_valid[s] = '0;
                ref_tree[s]  = '0;
            end
            pend_req.delete();
            pend_test.delete();
            up_in_use = 0;
            resp_held = 0;
        end else begin
            if (req_valid) begin
                pend_req.push_back(req);
                pend_test.push_back(test_id);
                up_in_use++;
            end
            if (req_credit) begin
                if (up_in_use == 0) begin
                    protocol_count++;
                    $display("Request credit returned while no request was outstanding");
                end else begin
                    up_in_use--;
                end
            end
            if (resp_valid) begin
                if (resp_held >= RESP_CREDITS) begin
                    protocol_count++;
                    $display("Response sent while the consumer had no free credit");
                end
                resp_held++;
                if (pend_req.size() == 0) begin
                    protocol_count++;
                    $display("Response arrived with no pending request");
                end else begin
                    r        = pend_req.pop_front();
                    id       = pend_test.pop_front();
                    exp_resp = expected_resp(r);
                    if (resp !== exp_resp) begin
                        mismatch_count++;
                        $display("Error %s: expected hit=%0d way=%0d set=%0d tag=%02h, %s",
                            test_label(id), exp_resp.hit, exp_resp.way, exp_resp.set_idx,
                            exp_resp.tag, $sformatf("actual hit=%0d way=%0d set=%0d tag=%02h",
                            resp.hit, resp.way, resp.set_idx, resp.tag));
                    end
                end
            end
            if (resp_credit && resp_held > 0) begin
                resp_held--;
            end
        end
    end

endmodule

// File: tb_l2_way_select.sv
module tb_l2_way_select;
    import l2_way_pkg::*;

    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int RAND_COUNT     = 200;
    localparam int DIRECTED_COUNT = 64;
    // Random credit delays and idle gaps stay well below this per request
    localparam int PER_REQ_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = (DIRECTED_COUNT + RAND_COUNT) * PER_REQ_CYCLES + 400;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    l2_req_t     req;
    logic        req_credit;
    logic        resp_valid;
    l2_resp_t    resp;
    logic        resp_credit;
    int          test_id;
    int          sent_count;
    int          credits_back;
    int          resp_seen;
    int          returned;
    int          delay_left;
    logic        credit_next;
    logic        withhold;
    logic        rand_delays;
    logic [31:0] rng;
    int          cycle_count;
    int          seq_errors;
    int          mismatch_count;
    int          protocol_count;

    l2_way_select_top l2_way_select_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    tb_l2_checker checker_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .resp_credit    (resp_credit),
        .test_id        (test_id),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    ////////////////////
    // Credit models
    ////////////////////

    // Upstream credits counted at the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            credits_back = 0;
        end else if (req_credit) begin
            credits_back++;
        end
    end

    // Consumer, returns one credit per response unless withheld
    always @(negedge clk) begin
        if (!arst_n) begin
            resp_seen   = 0;
            returned    = 0;
            delay_left  = 0;
            credit_next = 1'b0;
        end else begin
            if (resp_valid) begin
                resp_seen++;
            end
            credit_next = 1'b0;
            if (delay_left > 0) begin
                delay_left--;
            end else if (!withhold && returned < resp_seen) begin
                credit_next = 1'b1;
                returned++;
                if (rand_delays) begin
                    rng        = next_random(rng);
                    delay_left = int'(rng[1:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        #DRIVE_DELAY resp_credit = credit_next;
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic send_req(input logic [SET_W-1:0] s, input logic [TAG_W-1:0] t,
                            input logic i);
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
        while (sent_count - credits_back >= REQ_CREDITS) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req_valid     = 1'b1;
        req.set_idx   = s;
        req.tag       = t;
        req.instr     = i;
        sent_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            req_valid = 1'b0;
        end
    endtask

    // Every response seen and every credit handed back
    task automatic wait_idle();
        idle_cycles(1);
        while (resp_seen != sent_count || returned != resp_seen) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic check_quiet();
        if (resp_valid !== 1'b0 || req_credit !== 1'b0) begin
            seq_errors++;
            $display("Error reset_fill: expected resp_valid=0 req_credit=0, actual %b %b",
                resp_valid, req_credit);
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d responses seen",
            cycle_count, resp_seen, sent_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int base_resp;
        int base_back;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        resp_credit = 1'b0;
        credit_next = 1'b0;
        withhold    = 1'b0;
        rand_delays = 1'b0;
        rng         = 32'd48232;
        test_id     = 1;
        sent_count  = 0;
        seq_errors  = 0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        check_quiet();
        arst_n = 1'b1;
        idle_cycles(1);
        check_quiet();

        // Data misses fill ways 7 down to 0, then the same tags hit
        for (int k = 0; k < 2 * NUM_WAYS; k++) begin
            send_req(4'd3, 8'h10 + 8'(k % NUM_WAYS), 1'b0);
        end
        wait_idle();

        test_id = 2;
        for (int k = 0; k < 10; k++) begin
            send_req(4'd9, 8'h20 + 8'(k), 1'b1);
        end
        send_req(4'd9, 8'h30, 1'b0);
        wait_idle();

        // Full set, some hits to steer the tree, then evictions
        test_id = 3;
        for (int k = 0; k < NUM_WAYS; k++) begin
            send_req(4'd12, 8'h40 + 8'(k), 1'b0);
        end
        send_req(4'd12, 8'h47, 1'b0);
        send_req(4'd12, 8'h43, 1'b0);
        send_req(4'd12, 8'h45, 1'b0);
        for (int k = 0; k < 4; k++) begin
            send_req(4'd12, 8'h50 + 8'(k), 1'b0);
        end
        send_req(4'd12, 8'h60, 1'b1);
        wait_idle();

        // Back to back in one set, with a second set in between
        test_id = 4;
        send_req(4'd6, 8'h70, 1'b0);
        send_req(4'd6, 8'h70, 1'b0);
        send_req(4'd6, 8'h71, 1'b0);
        send_req(4'd7, 8'h70, 1'b0);
        send_req(4'd6, 8'h70, 1'b0);
        send_req(4'd6, 8'h72, 1'b1);
        send_req(4'd7, 8'h70, 1'b0);
        send_req(4'd6, 8'h71, 1'b0);
        wait_idle();

        test_id   = 5;
        withhold  = 1'b1;
        base_resp = resp_seen;
        base_back = credits_back;
        for (int k = 0; k < 2 * REQ_CREDITS; k++) begin
            send_req(SET_W'(k), 8'h80 + 8'(k), 1'b0);
        end
        idle_cycles(12);
        if (resp_seen - base_resp != RESP_CREDITS) begin
            seq_errors++;
            $display("Error credits: expected %0d responses, actual %0d",
                RESP_CREDITS, resp_seen - base_resp);
        end
        if (credits_back - base_back != RESP_CREDITS) begin
            seq_errors++;
            $display("Error credits: expected %0d upstream credits, actual %0d",
                RESP_CREDITS, credits_back - base_back);
        end
        withhold = 1'b0;
        wait_idle();

        test_id     = 6;
        rand_delays = 1'b1;
        for (int k = 0; k < RAND_COUNT; k++) begin
            rng = next_random(rng);
            send_req(rng[SET_W-1:0], {4'hc, rng[7:4]}, rng[8]);
            if (rng[11:10] == 2'b00) begin
                idle_cycles(1);
            end
        end
        wait_idle();

        $display("Errors: %0d mismatches, %0d protocol, %0d sequence, %0d responses",
            mismatch_count, protocol_count, seq_errors, resp_seen);
        if (mismatch_count + protocol_count + seq_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
